// File: arq_tx.f
hdl/arq_noc_pkg.sv
hdl/arq_tx_pkg.sv
hdl/arq_dual_port_ram.sv
hdl/arq_ack_fifo.sv
hdl/arq_tx_ingress.sv
hdl/arq_tx_egress.sv
hdl/arq_ack_handler.sv
hdl/arq_tx.sv
sim/arq_tx_assertions.sv
sim/arq_tx_tb.sv

// File: hdl/arq_ack_fifo.sv
`timescale 1ns/1ps

module arq_ack_fifo #(
    parameter int ADDR_W = 2
) (
    input  logic                   clk_i,
    input  logic                   reset_q_i,
    input  logic                   wr_en_i,
    input  arq_noc_pkg::noc_flit_t wr_data_i,
    input  logic                   rd_en_i,
    output logic                   full_o,
    output arq_noc_pkg::noc_flit_t rd_data_o,
    output logic                   empty_o
);

    localparam int DEPTH = 2**ADDR_W;

    arq_noc_pkg::noc_flit_t mem [0:DEPTH-1];
    logic [ADDR_W:0]        wr_ptr_q;
    logic [ADDR_W:0]        rd_ptr_q;
    logic                   do_wr;
    logic                   do_rd;

    // extra msb tells a full FIFO from an empty one
    assign full_o  = (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]) &&
                     (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]);
    assign empty_o = (wr_ptr_q == rd_ptr_q);

    assign do_wr = wr_en_i && !full_o;
    assign do_rd = rd_en_i && !empty_o;

    // head is visible without a read cycle
    assign rd_data_o = mem[rd_ptr_q[ADDR_W-1:0]];

    always_ff @(posedge clk_i or negedge reset_q_i) begin
        if (!reset_q_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr_q[ADDR_W-1:0]] <= wr_data_i;
        end
    end

endmodule

// File: hdl/arq_ack_handler.sv
`timescale 1ns/1ps

module arq_ack_handler #(
    parameter int BUF_ADDR_W = 3
) (
    input  logic                      clk_i,
    input  logic                      reset_q_i,
    input  logic                      ack_empty_i,
    input  arq_noc_pkg::noc_flit_t    ack_flit_i,
    input  logic [BUF_ADDR_W:0]       wr_ptr_i,
    input  logic [2**BUF_ADDR_W-1:0]  entry_set_i,
    input  arq_tx_pkg::pkt_info_t     info_rd_data_i,
    input  logic                      resend_done_i,
    output logic                      ack_pop_o,
    output logic                      info_rd_en_o,
    output logic [BUF_ADDR_W-1:0]     info_rd_addr_o,
    output logic [BUF_ADDR_W:0]       occ_ptr_o,
    output logic                      resend_req_o,
    output logic [BUF_ADDR_W-1:0]     resend_idx_o
);

    localparam int DEPTH = 2**BUF_ADDR_W;

    arq_tx_pkg::ack_state_e state_q;
    arq_tx_pkg::ack_state_e state_d;
    logic [BUF_ADDR_W:0]    scan_ptr_q;
    logic [BUF_ADDR_W:0]    occ_ptr_q;
    logic [DEPTH-1:0]       valid_q;
    logic [DEPTH-1:0]       clr_mask;
    logic [BUF_ADDR_W-1:0]  scan_idx;
    logic                   match;
    logic                   is_ack;
    logic                   release_step;
    logic                   resend_req_q;
    logic [BUF_ADDR_W-1:0]  resend_idx_q;

    assign scan_idx = scan_ptr_q[BUF_ADDR_W-1:0];
    assign is_ack   = ack_flit_i.payload.data[arq_noc_pkg::ACK_FLAG_BIT];

    // the ACK is sent back by our target, so its source ids are our target ids
    assign match = valid_q[scan_idx] &&
                   (ack_flit_i.header.src_modid == info_rd_data_i.trg_modid) &&
                   (ack_flit_i.header.src_chipid == info_rd_data_i.trg_chipid) &&
                   (ack_flit_i.payload.addr == info_rd_data_i.addr) &&
                   (ack_flit_i.payload.mode == info_rd_data_i.mode);

    // oldest entry already acked, slot can be reused
    assign release_step = (occ_ptr_q != wr_ptr_i) && !valid_q[occ_ptr_q[BUF_ADDR_W-1:0]];

    always_comb begin
        state_d      = state_q;
        ack_pop_o    = 1'b0;
        info_rd_en_o = 1'b0;
        clr_mask     = '0;
        case (state_q)
            arq_tx_pkg::ACK_IDLE: begin
                if (!ack_empty_i) begin
                    state_d = arq_tx_pkg::ACK_READ;
                end
            end
            arq_tx_pkg::ACK_READ: begin
                if (scan_ptr_q == wr_ptr_i) begin
                    // scanned everything without a match, drop it
                    ack_pop_o = 1'b1;
                    state_d   = arq_tx_pkg::ACK_IDLE;
                end else begin
                    info_rd_en_o = 1'b1;
                    state_d      = arq_tx_pkg::ACK_CHECK;
                end
            end
            arq_tx_pkg::ACK_CHECK: begin
                if (match) begin
                    ack_pop_o = 1'b1;
                    if (is_ack) begin
                        clr_mask = DEPTH'(1) << scan_idx;
                        state_d  = arq_tx_pkg::ACK_RELEASE;
                    end else begin
                        state_d = arq_tx_pkg::ACK_RESEND_WAIT;
                    end
                end else begin
                    state_d = arq_tx_pkg::ACK_READ;
                end
            end
            arq_tx_pkg::ACK_RELEASE: begin
                if (!release_step) begin
                    state_d = arq_tx_pkg::ACK_IDLE;
                end
            end
            arq_tx_pkg::ACK_RESEND_WAIT: begin
                if (resend_done_i) begin
                    state_d = arq_tx_pkg::ACK_IDLE;
                end
            end
            default: state_d = arq_tx_pkg::ACK_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge reset_q_i) begin
        if (!reset_q_i) begin
            state_q      <= arq_tx_pkg::ACK_IDLE;
            scan_ptr_q   <= '0;
            occ_ptr_q    <= '0;
            valid_q      <= '0;
            resend_req_q <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_q <= (valid_q | entry_set_i) & ~clr_mask;
            // every scan starts at the oldest entry
            if (state_q == arq_tx_pkg::ACK_IDLE) begin
                scan_ptr_q <= occ_ptr_q;
            end else if ((state_q == arq_tx_pkg::ACK_CHECK) && !match) begin
                scan_ptr_q <= scan_ptr_q + 1'b1;
            end
            if ((state_q == arq_tx_pkg::ACK_RELEASE) && release_step) begin
                occ_ptr_q <= occ_ptr_q + 1'b1;
            end
            if ((state_q == arq_tx_pkg::ACK_CHECK) && match && !is_ack) begin
                resend_req_q <= 1'b1;
            end else if (resend_done_i) begin
                resend_req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == arq_tx_pkg::ACK_CHECK) && match && !is_ack) begin
            resend_idx_q <= scan_idx;
        end
    end

    assign info_rd_addr_o = scan_idx;
    assign occ_ptr_o      = occ_ptr_q;
    assign resend_req_o   = resend_req_q;
    assign resend_idx_o   = resend_idx_q;

endmodule

// File: hdl/arq_dual_port_ram.sv
`timescale 1ns/1ps

module arq_dual_port_ram #(
    parameter int  ADDR_W = 3,
    parameter int  DATA_W = 8,
    parameter type data_t = logic [DATA_W-1:0]
) (
    input  logic              clk_i,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  data_t             wr_data_i,
    input  logic              rd_en_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output data_t             rd_data_o
);

    logic [DATA_W-1:0] mem [0:2**ADDR_W-1];

    // read data holds while rd_en_i is low
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= DATA_W'(wr_data_i);
        end
        if (rd_en_i) begin
            rd_data_o <= data_t'(mem[rd_addr_i]);
        end
    end

endmodule

// File: hdl/arq_noc_pkg.sv
package arq_noc_pkg;

    // field widths of the NoC flit
    typedef logic [7:0]  modid_t;
    typedef logic [5:0]  chipid_t;
    typedef logic [31:0] noc_addr_t;
    typedef logic [3:0]  noc_mode_t;
    typedef logic [63:0] noc_data_t;

    typedef struct packed {
        logic    arq;
        modid_t  src_modid;
        chipid_t src_chipid;
        modid_t  trg_modid;
        chipid_t trg_chipid;
    } noc_header_t;

    typedef struct packed {
        noc_mode_t mode;
        noc_addr_t addr;
        noc_data_t data;
    } noc_payload_t;

    typedef struct packed {
        noc_header_t  header;
        noc_payload_t payload;
    } noc_flit_t;

    // data bit of an ACK flit, 1 for ACK and 0 for NACK
    localparam int ACK_FLAG_BIT = 0;

endpackage

// File: hdl/arq_tx.sv
`timescale 1ns/1ps

module arq_tx #(
    parameter int BUF_ADDR_W      = 3,
    parameter int ACK_FIFO_ADDR_W = 2
) (
    input  logic                   clk_i,
    input  logic                   reset_q_i,
    input  logic                   arq_enable_i,
    input  logic                   mod_wrreq_i,
    input  arq_noc_pkg::noc_flit_t mod_flit_i,
    output logic                   mod_stall_o,
    output logic                   noc_wrreq_o,
    output arq_noc_pkg::noc_flit_t noc_flit_o,
    input  logic                   noc_stall_i,
    input  logic                   ack_wrreq_i,
    input  arq_noc_pkg::noc_flit_t ack_flit_i,
    output logic                   ack_stall_o
);

    localparam int DEPTH = 2**BUF_ADDR_W;

    logic                   forward;
    logic                   buf_wr_en;
    logic [BUF_ADDR_W:0]    wr_ptr;
    logic [BUF_ADDR_W:0]    occ_ptr;
    logic [DEPTH-1:0]       entry_set;
    arq_tx_pkg::pkt_info_t  info_wr_data;
    arq_tx_pkg::pkt_info_t  info_rd_data;
    logic                   info_rd_en;
    logic [BUF_ADDR_W-1:0]  info_rd_addr;
    logic                   buf_rd_en;
    logic [BUF_ADDR_W-1:0]  buf_rd_addr;
    arq_noc_pkg::noc_flit_t buf_rd_data;
    logic                   egress_busy;
    logic                   resend_req;
    logic [BUF_ADDR_W-1:0]  resend_idx;
    logic                   resend_done;
    logic                   ack_pop;
    logic                   ack_empty;
    arq_noc_pkg::noc_flit_t ack_head;

    arq_tx_ingress #(.BUF_ADDR_W(BUF_ADDR_W)) ingress_i (
        .clk_i, .reset_q_i, .arq_enable_i, .mod_wrreq_i, .mod_flit_i,
        .occ_ptr_i      (occ_ptr),
        .egress_busy_i  (egress_busy),
        .noc_stall_i,
        .mod_stall_o,
        .forward_o      (forward),
        .buf_wr_en_o    (buf_wr_en),
        .wr_ptr_o       (wr_ptr),
        .info_wr_data_o (info_wr_data),
        .entry_set_o    (entry_set)
    );

    // transmit buffer, one flit per entry
    arq_dual_port_ram #(
        .ADDR_W (BUF_ADDR_W),
        .DATA_W ($bits(arq_noc_pkg::noc_flit_t)),
        .data_t (arq_noc_pkg::noc_flit_t)
    ) flit_ram (
        .clk_i,
        .wr_en_i   (buf_wr_en),
        .wr_addr_i (wr_ptr[BUF_ADDR_W-1:0]),
        .wr_data_i (mod_flit_i),
        .rd_en_i   (buf_rd_en),
        .rd_addr_i (buf_rd_addr),
        .rd_data_o (buf_rd_data)
    );

    // match fields of each entry for the ACK scan
    arq_dual_port_ram #(
        .ADDR_W (BUF_ADDR_W),
        .DATA_W ($bits(arq_tx_pkg::pkt_info_t)),
        .data_t (arq_tx_pkg::pkt_info_t)
    ) info_ram (
        .clk_i,
        .wr_en_i   (buf_wr_en),
        .wr_addr_i (wr_ptr[BUF_ADDR_W-1:0]),
        .wr_data_i (info_wr_data),
        .rd_en_i   (info_rd_en),
        .rd_addr_i (info_rd_addr),
        .rd_data_o (info_rd_data)
    );

    arq_tx_egress #(.BUF_ADDR_W(BUF_ADDR_W)) egress_i (
        .clk_i, .reset_q_i, .arq_enable_i,
        .forward_i      (forward),
        .mod_flit_i, .mod_wrreq_i,
        .wr_ptr_i       (wr_ptr),
        .buf_rd_data_i  (buf_rd_data),
        .noc_stall_i,
        .resend_req_i   (resend_req),
        .resend_idx_i   (resend_idx),
        .buf_rd_en_o    (buf_rd_en),
        .buf_rd_addr_o  (buf_rd_addr),
        .busy_o         (egress_busy),
        .resend_done_o  (resend_done),
        .noc_wrreq_o, .noc_flit_o
    );

    arq_ack_fifo #(.ADDR_W(ACK_FIFO_ADDR_W)) ack_fifo_i (
        .clk_i, .reset_q_i,
        .wr_en_i   (ack_wrreq_i),
        .wr_data_i (ack_flit_i),
        .rd_en_i   (ack_pop),
        .full_o    (ack_stall_o),
        .rd_data_o (ack_head),
        .empty_o   (ack_empty)
    );

    arq_ack_handler #(.BUF_ADDR_W(BUF_ADDR_W)) ack_handler_i (
        .clk_i, .reset_q_i,
        .ack_empty_i    (ack_empty),
        .ack_flit_i     (ack_head),
        .wr_ptr_i       (wr_ptr),
        .entry_set_i    (entry_set),
        .info_rd_data_i (info_rd_data),
        .resend_done_i  (resend_done),
        .ack_pop_o      (ack_pop),
        .info_rd_en_o   (info_rd_en),
        .info_rd_addr_o (info_rd_addr),
        .occ_ptr_o      (occ_ptr),
        .resend_req_o   (resend_req),
        .resend_idx_o   (resend_idx)
    );

endmodule

// File: hdl/arq_tx_egress.sv
`timescale 1ns/1ps

module arq_tx_egress #(
    parameter int BUF_ADDR_W = 3
) (
    input  logic                   clk_i,
    input  logic                   reset_q_i,
    input  logic                   arq_enable_i,
    input  logic                   forward_i,
    input  arq_noc_pkg::noc_flit_t mod_flit_i,
    input  logic                   mod_wrreq_i,
    input  logic [BUF_ADDR_W:0]    wr_ptr_i,
    input  arq_noc_pkg::noc_flit_t buf_rd_data_i,
    input  logic                   noc_stall_i,
    input  logic                   resend_req_i,
    input  logic [BUF_ADDR_W-1:0]  resend_idx_i,
    output logic                   buf_rd_en_o,
    output logic [BUF_ADDR_W-1:0]  buf_rd_addr_o,
    output logic                   busy_o,
    output logic                   resend_done_o,
    output logic                   noc_wrreq_o,
    output arq_noc_pkg::noc_flit_t noc_flit_o
);

    arq_tx_pkg::egress_state_e state_q;
    arq_tx_pkg::egress_state_e state_d;
    logic [BUF_ADDR_W:0]       rd_ptr_q;
    logic                      out_valid_q;
    logic                      hold_valid_q;
    arq_noc_pkg::noc_flit_t    hold_q;
    arq_noc_pkg::noc_flit_t    ram_flit;
    logic                      rd_go;
    logic                      send_more;

    // a pending resend ends the send run so it cannot starve
    assign send_more = (rd_ptr_q != wr_ptr_i) && !resend_req_i;

    always_comb begin
        state_d = state_q;
        rd_go   = 1'b0;
        case (state_q)
            arq_tx_pkg::EG_IDLE: begin
                if (resend_req_i) begin
                    state_d = arq_tx_pkg::EG_RESEND;
                end else if (rd_ptr_q != wr_ptr_i) begin
                    state_d = arq_tx_pkg::EG_SEND;
                end
            end
            arq_tx_pkg::EG_SEND: begin
                if (!noc_stall_i) begin
                    if (send_more) begin
                        rd_go = 1'b1;
                    end else begin
                        state_d = arq_tx_pkg::EG_IDLE;
                    end
                end
            end
            arq_tx_pkg::EG_RESEND: begin
                // one read, then wait until the NoC takes it
                if (!noc_stall_i) begin
                    if (!out_valid_q) begin
                        rd_go = 1'b1;
                    end else begin
                        state_d = arq_tx_pkg::EG_IDLE;
                    end
                end
            end
            default: state_d = arq_tx_pkg::EG_IDLE;
        endcase
    end

    assign buf_rd_en_o   = rd_go;
    assign buf_rd_addr_o = (state_q == arq_tx_pkg::EG_RESEND) ? resend_idx_i
                                                              : rd_ptr_q[BUF_ADDR_W-1:0];
    assign busy_o        = (state_q != arq_tx_pkg::EG_IDLE);
    assign resend_done_o = (state_q == arq_tx_pkg::EG_RESEND) && out_valid_q && !noc_stall_i;

    always_ff @(posedge clk_i or negedge reset_q_i) begin
        if (!reset_q_i) begin
            state_q      <= arq_tx_pkg::EG_IDLE;
            rd_ptr_q     <= '0;
            out_valid_q  <= 1'b0;
            hold_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (rd_go && (state_q == arq_tx_pkg::EG_SEND)) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (!noc_stall_i) begin
                out_valid_q <= rd_go;
            end
            hold_valid_q <= out_valid_q && noc_stall_i;
        end
    end

    // capture the RAM output on the first stalled cycle
    always_ff @(posedge clk_i) begin
        if (out_valid_q && noc_stall_i && !hold_valid_q) begin
            hold_q <= ram_flit;
        end
    end

    always_comb begin
        ram_flit            = buf_rd_data_i;
        ram_flit.header.arq = arq_enable_i;
        if (forward_i && (state_q == arq_tx_pkg::EG_IDLE)) begin
            noc_wrreq_o           = mod_wrreq_i;
            noc_flit_o            = mod_flit_i;
            noc_flit_o.header.arq = 1'b0;
        end else begin
            noc_wrreq_o = out_valid_q;
            noc_flit_o  = hold_valid_q ? hold_q : ram_flit;
        end
    end

endmodule

// File: hdl/arq_tx_ingress.sv
`timescale 1ns/1ps

module arq_tx_ingress #(
    parameter int BUF_ADDR_W = 3
) (
    input  logic                      clk_i,
    input  logic                      reset_q_i,
    input  logic                      arq_enable_i,
    input  logic                      mod_wrreq_i,
    input  arq_noc_pkg::noc_flit_t    mod_flit_i,
    input  logic [BUF_ADDR_W:0]       occ_ptr_i,
    input  logic                      egress_busy_i,
    input  logic                      noc_stall_i,
    output logic                      mod_stall_o,
    output logic                      forward_o,
    output logic                      buf_wr_en_o,
    output logic [BUF_ADDR_W:0]       wr_ptr_o,
    output arq_tx_pkg::pkt_info_t     info_wr_data_o,
    output logic [2**BUF_ADDR_W-1:0]  entry_set_o
);

    localparam int DEPTH = 2**BUF_ADDR_W;

    logic [BUF_ADDR_W:0] wr_ptr_q;
    logic                full;

    // same slot but one lap ahead of the oldest entry
    assign full = (wr_ptr_q[BUF_ADDR_W-1:0] == occ_ptr_i[BUF_ADDR_W-1:0]) &&
                  (wr_ptr_q[BUF_ADDR_W] != occ_ptr_i[BUF_ADDR_W]);

    assign forward_o   = !arq_enable_i;
    // forwarded flits wait for the NoC and for a running buffer send
    assign mod_stall_o = forward_o ? (noc_stall_i || egress_busy_i) : full;
    assign buf_wr_en_o = mod_wrreq_i && !forward_o && !full;
    assign wr_ptr_o    = wr_ptr_q;

    assign entry_set_o = buf_wr_en_o ? (DEPTH'(1) << wr_ptr_q[BUF_ADDR_W-1:0]) : '0;

    always_comb begin
        info_wr_data_o.trg_modid  = mod_flit_i.header.trg_modid;
        info_wr_data_o.trg_chipid = mod_flit_i.header.trg_chipid;
        info_wr_data_o.addr       = mod_flit_i.payload.addr;
        info_wr_data_o.mode       = mod_flit_i.payload.mode;
    end

    always_ff @(posedge clk_i or negedge reset_q_i) begin
        if (!reset_q_i) begin
            wr_ptr_q <= '0;
        end else if (buf_wr_en_o) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

endmodule

// File: hdl/arq_tx_pkg.sv
package arq_tx_pkg;

    // what an ACK has to match to release an entry
    typedef struct packed {
        arq_noc_pkg::modid_t    trg_modid;
        arq_noc_pkg::chipid_t   trg_chipid;
        arq_noc_pkg::noc_addr_t addr;
        arq_noc_pkg::noc_mode_t mode;
    } pkt_info_t;

    typedef enum logic [1:0] {
        EG_IDLE,
        EG_SEND,
        EG_RESEND
    } egress_state_e;

    typedef enum logic [2:0] {
        ACK_IDLE,
        ACK_READ,
        ACK_CHECK,
        ACK_RELEASE,
        ACK_RESEND_WAIT
    } ack_state_e;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the arq_tx testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module arq_tx_tb \
    -f arq_tx.f -o arq_tx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/arq_tx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0

// File: sim/arq_tx_assertions.sv
`timescale 1ns/1ps

module arq_tx_assertions (
    input logic                   clk_i,
    input logic                   reset_q_i,
    input logic                   noc_stall_i,
    input logic                   noc_wrreq_o,
    input arq_noc_pkg::noc_flit_t noc_flit_o,
    input logic                   mod_stall_o,
    input logic                   ack_stall_o
);

    // a flit refused by the NoC waits unchanged
    stall_holds_flit: assert property (@(posedge clk_i) disable iff (!reset_q_i)
        (noc_stall_i && noc_wrreq_o) |=> (noc_wrreq_o && $stable(noc_flit_o)))
        else $error("noc_wrreq_o or noc_flit_o changed during a NoC stall");

    known_control: assert property (@(posedge clk_i) disable iff (!reset_q_i)
        !$isunknown({noc_wrreq_o, mod_stall_o, ack_stall_o}))
        else $error("unknown value on a control output");

    known_flit: assert property (@(posedge clk_i) disable iff (!reset_q_i)
        noc_wrreq_o |-> !$isunknown(noc_flit_o))
        else $error("unknown value on noc_flit_o while noc_wrreq_o is high");

endmodule

bind arq_tx arq_tx_assertions arq_tx_assertions_i (
    .clk_i       (clk_i),
    .reset_q_i   (reset_q_i),
    .noc_stall_i (noc_stall_i),
    .noc_wrreq_o (noc_wrreq_o),
    .noc_flit_o  (noc_flit_o),
    .mod_stall_o (mod_stall_o),
    .ack_stall_o (ack_stall_o)
);

// File: sim/arq_tx_tb.sv
`timescale 1ns/1ps

module arq_tx_tb;

    typedef arq_noc_pkg::noc_flit_t flit_t;
    typedef arq_noc_pkg::noc_addr_t addr_t;

    localparam int BUF_ADDR_W = 3;
    localparam int DEPTH      = 2**BUF_ADDR_W;
    localparam int TIMEOUT    = 300;
    localparam int QUIET      = 12;

    logic  clk_i        = 1'b0;
    logic  reset_q_i    = 1'b0;
    logic  arq_enable_i = 1'b0;
    logic  mod_wrreq_i  = 1'b0;
    flit_t mod_flit_i   = '0;
    logic  noc_stall_i  = 1'b0;
    logic  ack_wrreq_i  = 1'b0;
    flit_t ack_flit_i   = '0;
    logic  mod_stall_o;
    logic  noc_wrreq_o;
    flit_t noc_flit_o;
    logic  ack_stall_o;

    logic [31:0] lfsr_q    = 32'he14c642a;
    addr_t       next_addr = 32'h0000_1000;
    bit          stall_en  = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          test_start_errors = 0;

    // reference model: expected NoC order plus outstanding entries by address, oldest first
    flit_t exp_q[$];
    flit_t seen_q[$];
    addr_t age_q[$];
    flit_t outstanding[addr_t];
    bit    acked[addr_t];

    arq_tx #(.BUF_ADDR_W(BUF_ADDR_W), .ACK_FIFO_ADDR_W(2)) arq_tx_i (
        .clk_i, .reset_q_i, .arq_enable_i, .mod_wrreq_i, .mod_flit_i, .mod_stall_o,
        .noc_wrreq_o, .noc_flit_o, .noc_stall_i, .ack_wrreq_i, .ack_flit_i, .ack_stall_o
    );

    always #20 clk_i = ~clk_i;

    // taps 32, 22, 2, 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[62:0], fb};
        end
        return r;
    endfunction

    // addresses stay unique so an ACK can name its flit
    function automatic flit_t make_flit();
        flit_t f;
        next_addr           = next_addr + 32'h10 + 32'(rand_bits(4));
        f.header.arq        = 1'(rand_bits(1));
        f.header.src_modid  = arq_noc_pkg::modid_t'(rand_bits(8));
        f.header.src_chipid = arq_noc_pkg::chipid_t'(rand_bits(6));
        f.header.trg_modid  = arq_noc_pkg::modid_t'(rand_bits(8));
        f.header.trg_chipid = arq_noc_pkg::chipid_t'(rand_bits(6));
        f.payload.mode      = arq_noc_pkg::noc_mode_t'(rand_bits(4));
        f.payload.addr      = next_addr;
        f.payload.data      = rand_bits(64);
        return f;
    endfunction

    function automatic void model_accept(input flit_t f);
        flit_t g;
        g            = f;
        g.header.arq = arq_enable_i;
        exp_q.push_back(g);
        if (arq_enable_i) begin
            outstanding[g.payload.addr] = g;
            age_q.push_back(g.payload.addr);
        end
    endfunction

    // space comes back only from the oldest end
    function automatic void model_ack(input addr_t addr);
        if (outstanding.exists(addr)) begin
            acked[addr] = 1'b1;
        end
        while (age_q.size() > 0 && acked.exists(age_q[0])) begin
            acked.delete(age_q[0]);
            outstanding.delete(age_q[0]);
            void'(age_q.pop_front());
        end
    endfunction

    function automatic int free_slots();
        return DEPTH - age_q.size();
    endfunction

    always @(negedge clk_i) begin
        noc_stall_i = stall_en && (rand_bits(2) == 64'd0);
    end

    always @(posedge clk_i) begin
        if (reset_q_i && noc_wrreq_o && !noc_stall_i) begin
            seen_q.push_back(noc_flit_o);
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic offer_flit(input flit_t f, input int max_cycles, output bit taken);
        int waited;
        taken  = 1'b0;
        waited = 0;
        @(negedge clk_i);
        mod_flit_i  = f;
        mod_wrreq_i = 1'b1;
        while (!taken && waited < max_cycles) begin
            @(posedge clk_i);
            taken = !mod_stall_o;
            waited++;
            @(negedge clk_i);
        end
        mod_wrreq_i = 1'b0;
        if (taken) begin
            model_accept(f);
        end
    endtask

    task automatic send_flit();
        flit_t f;
        bit    taken;
        f = make_flit();
        offer_flit(f, TIMEOUT, taken);
        checks++;
        assert (taken) else begin
            $display("timeout: flit for address %h was never accepted", f.payload.addr);
            errors++;
        end
    endtask

    task automatic fill_free();
        int n;
        n = free_slots();
        repeat (n) send_flit();
    endtask

    task automatic expect_stalled(input int cycles);
        bit taken;
        offer_flit(make_flit(), cycles, taken);
        check_bit("mod_stall_o", !taken, 1'b1);
    endtask

    task automatic push_ack(input flit_t f, input bit is_ack);
        flit_t a;
        int    waited;
        bit    taken;
        a                   = '0;
        a.header.src_modid  = f.header.trg_modid;
        a.header.src_chipid = f.header.trg_chipid;
        a.header.trg_modid  = f.header.src_modid;
        a.header.trg_chipid = f.header.src_chipid;
        a.payload.mode      = f.payload.mode;
        a.payload.addr      = f.payload.addr;
        a.payload.data      = rand_bits(64);
        a.payload.data[arq_noc_pkg::ACK_FLAG_BIT] = is_ack;
        taken  = 1'b0;
        waited = 0;
        @(negedge clk_i);
        ack_flit_i  = a;
        ack_wrreq_i = 1'b1;
        while (!taken && waited < TIMEOUT) begin
            @(posedge clk_i);
            taken = !ack_stall_o;
            waited++;
            @(negedge clk_i);
        end
        ack_wrreq_i = 1'b0;
        checks++;
        assert (taken) else begin
            $display("timeout: ACK for address %h was never queued", f.payload.addr);
            errors++;
        end
        if (taken && is_ack) begin
            model_ack(f.payload.addr);
        end else if (taken) begin
            exp_q.push_back(outstanding[f.payload.addr]);
        end
    endtask

    // compares what the NoC took with the model, then watches for extras
    task automatic check_outputs();
        int    waited;
        flit_t got;
        flit_t exp;
        waited = 0;
        while (seen_q.size() < exp_q.size() && waited < TIMEOUT) begin
            @(posedge clk_i);
            waited++;
        end
        checks++;
        assert (seen_q.size() >= exp_q.size()) else begin
            $display("timeout: only %0d of %0d flits left on the NoC", seen_q.size(),
                     exp_q.size());
            errors++;
        end
        while (exp_q.size() > 0 && seen_q.size() > 0) begin
            got = seen_q.pop_front();
            exp = exp_q.pop_front();
            checks++;
            assert (got === exp) else begin
                $display("[FAIL] %0t noc_flit_o: got %h, expected %h", $time, got, exp);
                errors++;
            end
        end
        exp_q.delete();
        repeat (QUIET) @(posedge clk_i);
        checks++;
        assert (seen_q.size() == 0) else begin
            $display("%0d flits left on the NoC that were not expected", seen_q.size());
            errors++;
        end
        seen_q.delete();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", tests, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    task automatic forward_test();
        stall_en = 1'b1;
        repeat (24) send_flit();
        check_outputs();
        end_test("forward with ARQ off");
    endtask

    task automatic buffered_test();
        addr_t order[$];
        addr_t tmp;
        int    j;
        @(negedge clk_i);
        arq_enable_i = 1'b1;
        repeat (3) begin
            fill_free();
            check_outputs();
            // acknowledge the batch in shuffled order
            order = age_q;
            for (int i = order.size() - 1; i > 0; i--) begin
                j        = int'(rand_bits(8)) % (i + 1);
                tmp      = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
            foreach (order[k]) push_ack(outstanding[order[k]], 1'b1);
        end
        end_test("buffered with ARQ on");
    endtask

    task automatic full_buffer_test();
        stall_en = 1'b0;
        fill_free();
        check_outputs();
        expect_stalled(30);
        push_ack(outstanding[age_q[0]], 1'b1);
        fill_free();
        expect_stalled(30);
        check_outputs();
        end_test("full buffer and oldest ACK");
    endtask

    task automatic release_order_test();
        push_ack(outstanding[age_q[1]], 1'b1);
        expect_stalled(30);
        push_ack(outstanding[age_q[0]], 1'b1);
        fill_free();
        expect_stalled(30);
        check_outputs();
        end_test("out of order ACK release");
    endtask

    task automatic nack_test();
        flit_t victim;
        flit_t older[$];
        stall_en = 1'b1;
        victim   = outstanding[age_q[3]];
        for (int i = 0; i < 3; i++) older.push_back(outstanding[age_q[i]]);
        push_ack(victim, 1'b0);
        check_outputs();
        push_ack(victim, 1'b1);
        foreach (older[k]) push_ack(older[k], 1'b1);
        fill_free();
        expect_stalled(30);
        check_outputs();
        end_test("NACK resend then ACK");
    endtask

    task automatic unmatched_ack_test();
        push_ack(make_flit(), 1'b1);
        expect_stalled(50);
        check_outputs();
        // the handler must still serve a real ACK afterwards
        push_ack(outstanding[age_q[0]], 1'b1);
        fill_free();
        check_outputs();
        end_test("unmatched ACK ignored");
    endtask

    initial begin
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        reset_q_i = 1'b1;
        @(posedge clk_i);
        check_bit("mod_stall_o", mod_stall_o, 1'b0);
        check_bit("noc_wrreq_o", noc_wrreq_o, 1'b0);
        check_bit("ack_stall_o", ack_stall_o, 1'b0);
        forward_test();
        buffered_test();
        full_buffer_test();
        release_order_test();
        nack_test();
        unmatched_ack_test();
        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed_tests,
                 checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
